/* source/dcache_pkg.sv */
package dcache_pkg;

  //////////////////////////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////////////////////////

  localparam int addr_bits = 32;
  localparam int data_bits = 64;
  localparam int offset_bits = 3;
  localparam int index_bits = 5;
  localparam int num_sets = 32;
  localparam int tag_bits = addr_bits - index_bits - offset_bits;
  localparam int mem_tag_bits = 4;

  // miss queue sizing, pointers count 0 to queue_depth
  localparam int queue_depth = 4;
  localparam int queue_ptr_bits = 3;

  typedef logic [addr_bits-1:0] addr_t;
  typedef logic [data_bits-1:0] data_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [tag_bits-1:0] tag_t;
  typedef logic [mem_tag_bits-1:0] mem_tag_t;
  typedef logic [queue_ptr_bits-1:0] queue_ptr_t;
  typedef logic [queue_ptr_bits-2:0] queue_index_t;

  typedef enum logic [1:0] {
    bus_none = 2'd0,
    bus_load = 2'd1
  } bus_command_e;

  typedef enum logic [1:0] {
    entry_empty,
    entry_pending,
    entry_sent,
    entry_done
  } entry_state_e;

  //////////////////////////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
    data_t data;
  } cache_line_t;

  // one write into the line storage
  typedef struct packed {
    index_t index;
    tag_t tag;
    data_t data;
    logic dirty;
  } line_write_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
  } line_out_t;

  typedef struct packed {
    bus_command_e command;
    addr_t addr;
  } mem_request_t;

  // response is the acceptance tag, data_tag names the returning data
  typedef struct packed {
    mem_tag_t response;
    mem_tag_t data_tag;
    data_t data;
  } mem_response_t;

endpackage

/* source/dcache_array.sv */
module dcache_array (
  input  logic                    clock,
  input  logic                    reset,

  input  dcache_pkg::addr_t       rd_addr,
  output logic                    rd_hit,
  output dcache_pkg::data_t       rd_data,

  input  logic                    line_write_valid,
  input  dcache_pkg::line_write_t line_write,

  output logic                    evict_valid,
  output dcache_pkg::line_out_t   evict
);

  dcache_pkg::cache_line_t lines [dcache_pkg::num_sets];

  dcache_pkg::index_t rd_index;
  dcache_pkg::tag_t rd_tag;
  dcache_pkg::cache_line_t rd_line;
  dcache_pkg::cache_line_t old_line;

  logic fill_skip;
  logic do_write;

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  assign rd_index = rd_addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
  assign rd_tag = rd_addr[dcache_pkg::addr_bits-1 -: dcache_pkg::tag_bits];

  // reads see the contents from before this cycle's write
  assign rd_line = lines[rd_index];
  assign rd_hit = rd_line.valid && (rd_line.tag == rd_tag);
  assign rd_data = rd_line.data;

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  assign old_line = lines[line_write.index];

  // fill arriving after a newer store to the same line
  assign fill_skip = line_write_valid && !line_write.dirty &&
                     old_line.valid && (old_line.tag == line_write.tag);

  assign do_write = line_write_valid && !fill_skip;

  // dirty line pushed out by a different tag
  assign evict_valid = do_write && old_line.valid && old_line.dirty &&
                       (old_line.tag != line_write.tag);

  assign evict.addr = {old_line.tag, line_write.index, {dcache_pkg::offset_bits{1'b0}}};
  assign evict.data = old_line.data;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < dcache_pkg::num_sets; i++) begin
        lines[i].valid <= 1'b0;
        lines[i].dirty <= 1'b0;
      end
    end else if (do_write) begin
      lines[line_write.index].valid <= 1'b1;
      lines[line_write.index].dirty <= line_write.dirty;
      lines[line_write.index].tag <= line_write.tag;
      lines[line_write.index].data <= line_write.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // a fill only meets its own line after a newer store made it dirty
  assert property (
    @(posedge clock) disable iff (reset)
    fill_skip |-> old_line.dirty
  ) else $error("clean write met a clean valid line with the same tag");

endmodule

/* source/miss_queue.sv */
module miss_queue (
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      miss_valid,
  input  dcache_pkg::addr_t         miss_addr,
  output logic                      miss_ready,

  output dcache_pkg::mem_request_t  mem_request,
  input  dcache_pkg::mem_response_t mem_response,

  output logic                      fill_valid,
  output dcache_pkg::line_out_t     fill,
  output dcache_pkg::line_write_t   fill_write
);

  // entries stay packed from slot 0, oldest first
  dcache_pkg::entry_state_e state [dcache_pkg::queue_depth];
  dcache_pkg::entry_state_e state_next [dcache_pkg::queue_depth];
  dcache_pkg::addr_t entry_addr [dcache_pkg::queue_depth];
  dcache_pkg::addr_t entry_addr_next [dcache_pkg::queue_depth];
  dcache_pkg::mem_tag_t entry_tag [dcache_pkg::queue_depth];
  dcache_pkg::mem_tag_t entry_tag_next [dcache_pkg::queue_depth];

  dcache_pkg::queue_ptr_t tail;
  dcache_pkg::queue_ptr_t tail_next;
  dcache_pkg::queue_ptr_t send_ptr;
  dcache_pkg::queue_ptr_t send_ptr_next;
  dcache_pkg::queue_ptr_t wait_ptr;
  dcache_pkg::queue_ptr_t wait_ptr_next;
  dcache_pkg::queue_index_t send_sel;
  dcache_pkg::queue_index_t wait_sel;

  dcache_pkg::addr_t line_addr;
  logic [dcache_pkg::queue_depth-1:0] addr_match;
  logic queued;
  logic full;
  logic enqueue;
  logic send_valid;
  logic accept;
  logic data_done;

  //////////////////////////////////////////////////////////////////////
  // lookup of a new miss
  //////////////////////////////////////////////////////////////////////

  assign line_addr = {miss_addr[dcache_pkg::addr_bits-1:dcache_pkg::offset_bits],
                      {dcache_pkg::offset_bits{1'b0}}};

  always_comb begin
    for (int i = 0; i < dcache_pkg::queue_depth; i++) begin
      addr_match[i] = (state[i] != dcache_pkg::entry_empty) && (entry_addr[i] == line_addr);
    end
  end

  assign queued = |addr_match;
  assign full = (tail == dcache_pkg::queue_ptr_t'(dcache_pkg::queue_depth));
  assign miss_ready = !miss_valid || queued || !full;
  assign enqueue = miss_valid && !queued && !full;

  //////////////////////////////////////////////////////////////////////
  // memory side
  //////////////////////////////////////////////////////////////////////

  assign send_sel = send_ptr[dcache_pkg::queue_ptr_bits-2:0];
  assign wait_sel = wait_ptr[dcache_pkg::queue_ptr_bits-2:0];

  // oldest entry not yet accepted
  assign send_valid = (send_ptr < tail);
  assign accept = send_valid && (mem_response.response != '0);

  // data returns in acceptance order
  assign data_done = (wait_ptr < send_ptr) && (entry_tag[wait_sel] == mem_response.data_tag);

  always_comb begin
    mem_request.command = dcache_pkg::bus_none;
    mem_request.addr = '0;
    if (send_valid) begin
      mem_request.command = dcache_pkg::bus_load;
      mem_request.addr = entry_addr[send_sel];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // queue update
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    entry_addr_next = entry_addr;
    entry_tag_next = entry_tag;
    tail_next = tail;
    send_ptr_next = send_ptr;
    wait_ptr_next = wait_ptr;

    if (data_done) begin
      state_next[wait_sel] = dcache_pkg::entry_done;
      wait_ptr_next = wait_ptr_next + 1'b1;
    end

    if (accept) begin
      state_next[send_sel] = dcache_pkg::entry_sent;
      entry_tag_next[send_sel] = mem_response.response;
      send_ptr_next = send_ptr_next + 1'b1;
    end

    // head was filled last cycle, shift everything down
    if (state[0] == dcache_pkg::entry_done) begin
      for (int i = 0; i < dcache_pkg::queue_depth - 1; i++) begin
        state_next[i] = state_next[i+1];
        entry_addr_next[i] = entry_addr_next[i+1];
        entry_tag_next[i] = entry_tag_next[i+1];
      end
      state_next[dcache_pkg::queue_depth-1] = dcache_pkg::entry_empty;
      tail_next = tail_next - 1'b1;
      send_ptr_next = send_ptr_next - 1'b1;
      wait_ptr_next = wait_ptr_next - 1'b1;
    end

    if (enqueue) begin
      state_next[tail_next[dcache_pkg::queue_ptr_bits-2:0]] = dcache_pkg::entry_pending;
      entry_addr_next[tail_next[dcache_pkg::queue_ptr_bits-2:0]] = line_addr;
      tail_next = tail_next + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < dcache_pkg::queue_depth; i++) begin
        state[i] <= dcache_pkg::entry_empty;
      end
      tail <= '0;
      send_ptr <= '0;
      wait_ptr <= '0;
      fill_valid <= 1'b0;
    end else begin
      state <= state_next;
      tail <= tail_next;
      send_ptr <= send_ptr_next;
      wait_ptr <= wait_ptr_next;
      fill_valid <= data_done;
    end
  end

  always_ff @(posedge clock) begin
    entry_addr <= entry_addr_next;
    entry_tag <= entry_tag_next;
    if (data_done) begin
      fill.addr <= entry_addr[wait_sel];
      fill.data <= mem_response.data;
    end
  end

  // fills go in clean
  assign fill_write.index = fill.addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
  assign fill_write.tag = fill.addr[dcache_pkg::addr_bits-1 -: dcache_pkg::tag_bits];
  assign fill_write.data = fill.data;
  assign fill_write.dirty = 1'b0;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  assert property (
    @(posedge clock) disable iff (reset)
    tail <= dcache_pkg::queue_ptr_t'(dcache_pkg::queue_depth)
  ) else $error("miss queue tail past depth");

  // memory hands data back strictly in acceptance order
  assert property (
    @(posedge clock) disable iff (reset)
    mem_response.data_tag != '0 |-> data_done
  ) else $error("returned data tag matches no sent entry");

  assert property (
    @(posedge clock) disable iff (reset)
    (mem_request.command == dcache_pkg::bus_load) && (mem_response.response == '0)
      |=> $stable(mem_request)
  ) else $error("memory request changed before acceptance");

endmodule

/* source/dcache.sv */
module dcache (
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      rd_valid,
  input  dcache_pkg::addr_t         rd_addr,
  output logic                      rd_ready,
  output logic                      rd_hit,
  output dcache_pkg::data_t         rd_data,

  input  logic                      wr_valid,
  input  dcache_pkg::addr_t         wr_addr,
  input  dcache_pkg::data_t         wr_data,
  output logic                      wr_ready,

  output dcache_pkg::mem_request_t  mem_request,
  input  dcache_pkg::mem_response_t mem_response,

  output logic                      fill_valid,
  output dcache_pkg::line_out_t     fill,

  output logic                      evict_valid,
  output dcache_pkg::line_out_t     evict
);

  dcache_pkg::line_write_t proc_write;
  dcache_pkg::line_write_t fill_write;
  dcache_pkg::line_write_t line_write;
  logic line_write_valid;
  logic miss_valid;

  // processor stores always mark the line dirty
  assign proc_write.index = wr_addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
  assign proc_write.tag = wr_addr[dcache_pkg::addr_bits-1 -: dcache_pkg::tag_bits];
  assign proc_write.data = wr_data;
  assign proc_write.dirty = 1'b1;

  // fill owns the single array write port
  assign wr_ready = !fill_valid;
  assign line_write_valid = fill_valid || (wr_valid && wr_ready);
  assign line_write = fill_valid ? fill_write : proc_write;

  assign miss_valid = rd_valid && !rd_hit;

  dcache_array cache_lines (
    .clock           (clock),
    .reset           (reset),
    .rd_addr         (rd_addr),
    .rd_hit          (rd_hit),
    .rd_data         (rd_data),
    .line_write_valid(line_write_valid),
    .line_write      (line_write),
    .evict_valid     (evict_valid),
    .evict           (evict)
  );

  miss_queue misses (
    .clock       (clock),
    .reset       (reset),
    .miss_valid  (miss_valid),
    .miss_addr   (rd_addr),
    .miss_ready  (rd_ready),
    .mem_request (mem_request),
    .mem_response(mem_response),
    .fill_valid  (fill_valid),
    .fill        (fill),
    .fill_write  (fill_write)
  );

endmodule

/* sim/mem_responder.sv */
module mem_responder (
  input  logic                      clock,
  input  logic                      stall,
  input  dcache_pkg::mem_request_t  mem_request,
  output dcache_pkg::mem_response_t mem_response,
  input  logic                      evict_valid,
  input  dcache_pkg::line_out_t     evict,
  output int                        accepted
);

  dcache_pkg::data_t store [dcache_pkg::addr_t];
  dcache_pkg::mem_tag_t return_tag [$];
  dcache_pkg::data_t return_data [$];
  int return_due [$];

  // contents of a line that was never written back
  function automatic dcache_pkg::data_t line_pattern(dcache_pkg::addr_t addr);
    return {addr ^ 32'h5a5a_0f0f, ~addr};
  endfunction

  // written-back lines land at the edge that evicts them
  always @(posedge clock) begin
    if (evict_valid) begin
      store[evict.addr] = evict.data;
    end
  end

  initial begin
    int seed;
    int cycle;
    int delay;
    dcache_pkg::mem_tag_t next_tag;
    dcache_pkg::data_t data;

    seed = 43;
    cycle = 0;
    delay = 0;
    next_tag = 4'd1;
    accepted = 0;
    mem_response = '0;
    forever begin
      @(negedge clock);
      cycle++;
      mem_response = '0;
      if (!stall) begin
        if (mem_request.command == dcache_pkg::bus_load) begin
          if (delay == 0) begin
            // the request is taken at the coming edge
            if (store.exists(mem_request.addr)) begin
              data = store[mem_request.addr];
            end else begin
              data = line_pattern(mem_request.addr);
            end
            mem_response.response = next_tag;
            return_tag.push_back(next_tag);
            return_data.push_back(data);
            return_due.push_back(cycle + 1 + ($random(seed) & 7));
            accepted++;
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            delay = $random(seed) & 3;
          end else begin
            delay--;
          end
        end
        // data goes back strictly in acceptance order
        if (return_tag.size() != 0 && return_due[0] <= cycle) begin
          mem_response.data_tag = return_tag.pop_front();
          mem_response.data = return_data.pop_front();
          void'(return_due.pop_front());
        end
      end
    end
  end

endmodule

/* sim/dcache_tb.sv */
module dcache_tb;

  localparam int random_cycles = 3000;
  localparam int fill_timeout = 200;
  localparam int drain_timeout = 500;

  logic clock;
  logic reset;
  logic rd_valid;
  dcache_pkg::addr_t rd_addr;
  logic rd_ready;
  logic rd_hit;
  dcache_pkg::data_t rd_data;
  logic wr_valid;
  dcache_pkg::addr_t wr_addr;
  dcache_pkg::data_t wr_data;
  logic wr_ready;
  dcache_pkg::mem_request_t mem_request;
  dcache_pkg::mem_response_t mem_response;
  logic fill_valid;
  dcache_pkg::line_out_t fill;
  logic evict_valid;
  dcache_pkg::line_out_t evict;
  logic stall;
  int accepted;

  int seed;
  int cycle;
  int requests_expected;
  int taken;
  logic fill_expected;

  // model memory and expected array contents, keyed by line address
  dcache_pkg::data_t model_mem [dcache_pkg::addr_t];
  logic dirty_lines [dcache_pkg::addr_t];
  int pending_since [dcache_pkg::addr_t];
  dcache_pkg::addr_t held_line [dcache_pkg::num_sets];
  logic held_valid [dcache_pkg::num_sets];

  dcache DUT (
    .clock       (clock),
    .reset       (reset),
    .rd_valid    (rd_valid),
    .rd_addr     (rd_addr),
    .rd_ready    (rd_ready),
    .rd_hit      (rd_hit),
    .rd_data     (rd_data),
    .wr_valid    (wr_valid),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .wr_ready    (wr_ready),
    .mem_request (mem_request),
    .mem_response(mem_response),
    .fill_valid  (fill_valid),
    .fill        (fill),
    .evict_valid (evict_valid),
    .evict       (evict)
  );

  mem_responder memory (
    .clock       (clock),
    .stall       (stall),
    .mem_request (mem_request),
    .mem_response(mem_response),
    .evict_valid (evict_valid),
    .evict       (evict),
    .accepted    (accepted)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic dcache_pkg::data_t line_pattern(dcache_pkg::addr_t addr);
    return {addr ^ 32'h5a5a_0f0f, ~addr};
  endfunction

  function automatic dcache_pkg::addr_t line_of(dcache_pkg::addr_t addr);
    return {addr[31:3], 3'b000};
  endfunction

  function automatic dcache_pkg::index_t index_of(dcache_pkg::addr_t addr);
    return addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
  endfunction

  function automatic dcache_pkg::data_t model_value(dcache_pkg::addr_t line);
    if (model_mem.exists(line)) begin
      return model_mem[line];
    end
    return line_pattern(line);
  endfunction

  // 16 lines over sets 0, 8, 16 and 24, four tags each
  function automatic dcache_pkg::addr_t pool_addr(logic [3:0] sel);
    dcache_pkg::tag_t tag;
    dcache_pkg::index_t idx;
    tag = dcache_pkg::tag_t'(sel[3:2]) + 24'h000100;
    idx = {sel[1:0], 3'b000};
    return {tag, idx, 3'b000};
  endfunction

  task automatic report_failure(input string line);
    $display("test failed");
    $display("%s", line);
    $fatal(1);
  endtask

  task automatic check_data(input string name, input dcache_pkg::data_t got,
                            input dcache_pkg::data_t expected);
    if (got !== expected) begin
      report_failure($sformatf("mismatch %s: got %h expected %h", name, got, expected));
    end
  endtask

  task automatic check_addr(input string name, input dcache_pkg::addr_t got,
                            input dcache_pkg::addr_t expected);
    if (got !== expected) begin
      report_failure($sformatf("mismatch %s: got %h expected %h", name, got, expected));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      report_failure($sformatf("mismatch %s: got %h expected %h", name, got, expected));
    end
  endtask

  task automatic check_command(input string name, input dcache_pkg::bus_command_e got,
                               input dcache_pkg::bus_command_e expected);
    if (got !== expected) begin
      report_failure($sformatf("mismatch %s: got %h expected %h", name, got, expected));
    end
  endtask

  task automatic check_count(input string name, input int got, input int expected);
    if (got != expected) begin
      report_failure($sformatf("mismatch %s: got %h expected %h", name, got, expected));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus and scoring
  //////////////////////////////////////////////////////////////////////

  task automatic drive_idle();
    rd_valid = 1'b0;
    wr_valid = 1'b0;
  endtask

  task automatic drive_random();
    logic [31:0] r;
    logic read_hits;

    r = $random(seed);
    rd_valid = r[0] | r[1];
    rd_addr = pool_addr(r[5:2]) | dcache_pkg::addr_t'(r[8:6]);
    wr_valid = r[9] & (r[10] | r[11]);
    wr_addr = pool_addr(r[15:12]) | dcache_pkg::addr_t'(r[18:16]);
    wr_data = {$random(seed), $random(seed)};
    read_hits = held_valid[index_of(rd_addr)] &&
                (held_line[index_of(rd_addr)] == line_of(rd_addr));
    // keep stores off lines with a fill on its way or about to miss
    if (pending_since.exists(line_of(wr_addr)) ||
        (rd_valid && !read_hits && line_of(wr_addr) == line_of(rd_addr))) begin
      wr_valid = 1'b0;
    end
  endtask

  // called at the rising edge, before the DUT state moves
  task automatic score_cycle();
    dcache_pkg::addr_t rd_line;
    dcache_pkg::addr_t new_line;
    dcache_pkg::addr_t old_line;
    dcache_pkg::index_t idx;
    logic hit_expected;
    logic ready_expected;
    logic write_taken;
    logic evict_expected;

    cycle++;
    rd_line = line_of(rd_addr);
    idx = index_of(rd_addr);
    hit_expected = held_valid[idx] && (held_line[idx] == rd_line);
    ready_expected = !rd_valid || hit_expected || pending_since.exists(rd_line) ||
                     (pending_since.num() < dcache_pkg::queue_depth);
    check_flag("rd_ready", rd_ready, ready_expected);
    if (rd_valid) begin
      check_flag("rd_hit", rd_hit, hit_expected);
      if (hit_expected) begin
        check_data("rd_data", rd_data, model_value(rd_line));
      end else if (rd_ready && !pending_since.exists(rd_line)) begin
        pending_since[rd_line] = cycle;
        requests_expected++;
      end
    end

    // data returned last cycle comes out as a fill now
    check_flag("fill_valid", fill_valid, fill_expected);
    check_flag("wr_ready", wr_ready, !fill_expected);
    write_taken = wr_valid && wr_ready;
    evict_expected = 1'b0;
    if (fill_valid) begin
      if (!pending_since.exists(fill.addr)) begin
        report_failure($sformatf("fill returned line %h without an outstanding miss",
                                 fill.addr));
      end
      check_data("fill.data", fill.data, model_value(fill.addr));
      pending_since.delete(fill.addr);
      new_line = fill.addr;
    end else begin
      new_line = line_of(wr_addr);
    end

    // the one array write of this cycle
    if (fill_valid || write_taken) begin
      idx = index_of(new_line);
      old_line = held_line[idx];
      evict_expected = held_valid[idx] && (old_line != new_line) &&
                       dirty_lines.exists(old_line);
      held_line[idx] = new_line;
      held_valid[idx] = 1'b1;
    end
    check_flag("evict_valid", evict_valid, evict_expected);
    if (evict_expected) begin
      check_addr("evict.addr", evict.addr, old_line);
      check_data("evict.data", evict.data, model_value(old_line));
      dirty_lines.delete(old_line);
    end
    if (write_taken) begin
      model_mem[new_line] = wr_data;
      dirty_lines[new_line] = 1'b1;
    end

    fill_expected = (mem_response.data_tag != '0);

    foreach (pending_since[key]) begin
      if (cycle - pending_since[key] > fill_timeout) begin
        report_failure($sformatf("no fill for line %h within %0d cycles", key, fill_timeout));
      end
    end
  endtask

  task automatic drain_queue();
    int waited;

    waited = 0;
    while (pending_since.num() != 0) begin
      if (waited == drain_timeout) begin
        report_failure("outstanding misses did not drain before the timeout");
      end
      @(negedge clock);
      drive_idle();
      @(posedge clock);
      score_cycle();
      waited++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed = 43;
    cycle = 0;
    requests_expected = 0;
    taken = 0;
    fill_expected = 1'b0;
    reset = 1'b1;
    stall = 1'b0;
    rd_valid = 1'b0;
    rd_addr = '0;
    wr_valid = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    for (int i = 0; i < dcache_pkg::num_sets; i++) begin
      held_valid[i] = 1'b0;
      held_line[i] = '0;
    end

    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    @(posedge clock);
    check_flag("rd_hit", rd_hit, 1'b0);
    check_flag("fill_valid", fill_valid, 1'b0);
    check_flag("evict_valid", evict_valid, 1'b0);
    check_command("mem_request.command", mem_request.command, dcache_pkg::bus_none);
    score_cycle();

    for (int n = 0; n < random_cycles; n++) begin
      @(negedge clock);
      drive_random();
      @(posedge clock);
      score_cycle();
    end
    drain_queue();

    // stalled memory, six new lines, four fit in the queue
    stall = 1'b1;
    for (int i = 0; i < 6; i++) begin
      @(negedge clock);
      drive_idle();
      rd_valid = 1'b1;
      rd_addr = {dcache_pkg::tag_t'(24'h00f000 + i), dcache_pkg::index_t'(i * 5), 3'b000};
      @(posedge clock);
      if (rd_ready) begin
        taken++;
      end
      score_cycle();
    end
    check_count("misses taken while stalled", taken, dcache_pkg::queue_depth);
    stall = 1'b0;
    drain_queue();

    check_count("memory requests", accepted, requests_expected);
    $display("test passed");
    $finish;
  end

endmodule

/* flist.f */
source/dcache_pkg.sv
source/dcache_array.sv
source/miss_queue.sv
source/dcache.sv
sim/mem_responder.sv
sim/dcache_tb.sv
